// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the TLB entry store testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_l1tlb_entry_store

verilator --binary --timing --assert \
    --top-module "${TOP}" \
    -f sim.f \
    -o "V${TOP}"
status=$?
if [ ${status} -ne 0 ]; then
    echo "Build failed with status ${status}"
    exit 1
fi

output=$(./obj_dir/V${TOP} 2>&1)
status=$?
echo "${output}"
if [ ${status} -ne 0 ]; then
    echo "Run ended with status ${status}"
    exit 1
fi

if echo "${output}" | grep -q "Simulation completed successfully"; then
    exit 0
fi

echo "Pass message not found"
exit 1

// File: sim.f
+incdir+tests
src/mmu_tlb_pkg.sv
src/tlb_update_if.sv
src/tlb_entry_array.sv
src/l1tlb_entry_store.sv
tests/tb_l1tlb_entry_store.sv

// File: src/l1tlb_entry_store.sv
`timescale 1ns/1ps

module l1tlb_entry_store #(
    parameter int NORMAL_ENTRIES = mmu_tlb_pkg::NORMAL_ENTRIES,
    parameter int SUPER_ENTRIES  = mmu_tlb_pkg::SUPER_ENTRIES
) (
    input  logic                               clk,
    input  logic                               rstn,

    // Write command with bit 0 for 4 KiB and bit 1 for superpage
    input  logic [1:0]                         i_write_en,
    input  mmu_tlb_pkg::pos_t                  i_write_pos,
    input  mmu_tlb_pkg::vpn_t                  i_write_vpn,
    input  mmu_tlb_pkg::asid_t                 i_write_asid,
    input  mmu_tlb_pkg::pte_t                  i_write_pte,

    // Flush command
    input  logic                               i_flush_en,
    input  mmu_tlb_pkg::vpn_t                  i_flush_vpn,
    input  mmu_tlb_pkg::asid_t                 i_flush_asid,
    input  logic [mmu_tlb_pkg::REG_IDX_W-1:0]  i_flush_rs1,
    input  logic [mmu_tlb_pkg::REG_IDX_W-1:0]  i_flush_rs2,

    // Lookup
    input  mmu_tlb_pkg::asid_t                 i_read_asid,
    input  mmu_tlb_pkg::vpn_t                  i_read_vpn,
    output mmu_tlb_pkg::hit_kind_t             o_hit,
    output mmu_tlb_pkg::pte_t                  o_hit_pte,

    // Valid vectors for replacement
    output logic [NORMAL_ENTRIES-1:0]          o_normal_valid,
    output logic [SUPER_ENTRIES-1:0]           o_super_valid
);

    import mmu_tlb_pkg::*;

    // ======================================================================
    // Command split and strobe priority
    // ======================================================================

    tlb_update_if u_normal_upd ();
    tlb_update_if u_super_upd ();

    logic fl_strobe;
    logic fl_all_vpn;
    logic fl_all_asid;

    // 4 KiB write beats superpage write beats flush
    assign fl_strobe   = i_flush_en && (i_write_en == 2'b00);
    assign fl_all_vpn  = (i_flush_rs1 == '0);
    assign fl_all_asid = (i_flush_rs2 == '0);

    assign u_normal_upd.wr_en       = i_write_en[0];
    assign u_normal_upd.wr_pos      = i_write_pos;
    assign u_normal_upd.wr_asid     = i_write_asid;
    assign u_normal_upd.wr_vpn      = i_write_vpn;
    assign u_normal_upd.wr_pte      = i_write_pte;
    assign u_normal_upd.fl_en       = fl_strobe;
    assign u_normal_upd.fl_asid     = i_flush_asid;
    assign u_normal_upd.fl_vpn      = i_flush_vpn;
    assign u_normal_upd.fl_all_asid = fl_all_asid;
    assign u_normal_upd.fl_all_vpn  = fl_all_vpn;

    assign u_super_upd.wr_en       = i_write_en[1] && !i_write_en[0];
    assign u_super_upd.wr_pos      = i_write_pos;
    assign u_super_upd.wr_asid     = i_write_asid;
    assign u_super_upd.wr_vpn      = i_write_vpn;
    assign u_super_upd.wr_pte      = i_write_pte;
    assign u_super_upd.fl_en       = fl_strobe;
    assign u_super_upd.fl_asid     = i_flush_asid;
    assign u_super_upd.fl_vpn      = i_flush_vpn;
    assign u_super_upd.fl_all_asid = fl_all_asid;
    assign u_super_upd.fl_all_vpn  = fl_all_vpn;

    // ======================================================================
    // Entry arrays
    // ======================================================================

    logic normal_hit;
    logic super_hit;
    pte_t normal_pte;
    pte_t super_pte;

    tlb_entry_array #(
        .DEPTH        (NORMAL_ENTRIES),
        .VPN_TAG_BITS (VPN_W)
    ) u_normal_array (
        .clk     (clk),
        .rstn    (rstn),
        .upd     (u_normal_upd),
        .i_asid  (i_read_asid),
        .i_vpn   (i_read_vpn),
        .o_hit   (normal_hit),
        .o_pte   (normal_pte),
        .o_valid (o_normal_valid)
    );

    tlb_entry_array #(
        .DEPTH        (SUPER_ENTRIES),
        .VPN_TAG_BITS (SUPER_VPN_BITS)
    ) u_super_array (
        .clk     (clk),
        .rstn    (rstn),
        .upd     (u_super_upd),
        .i_asid  (i_read_asid),
        .i_vpn   (i_read_vpn),
        .o_hit   (super_hit),
        .o_pte   (super_pte),
        .o_valid (o_super_valid)
    );

    // A 4 KiB hit outranks a superpage hit
    always_comb begin
        if (normal_hit) begin
            o_hit     = HIT_NORMAL;
            o_hit_pte = normal_pte;
        end else if (super_hit) begin
            o_hit     = HIT_SUPER;
            o_hit_pte = super_pte;
        end else begin
            o_hit     = HIT_NONE;
            o_hit_pte = '0;
        end
    end

    // With both write bits set the superpage table stays untouched
    a_normal_write_wins: assert property (
        @(posedge clk) disable iff (!rstn)
        (i_write_en == 2'b11) |=> $stable(o_super_valid)
    );

endmodule

// File: src/mmu_tlb_pkg.sv
package mmu_tlb_pkg;

    // ======================================================================
    // Widths of the lookup key and of the stored entry
    // ======================================================================

    parameter int ASID_W = 9;
    parameter int VPN_W  = 20;
    parameter int PTE_W  = 32;

    // Source-register number carried with the flush command
    parameter int REG_IDX_W = 5;

    // ======================================================================
    // Table geometry
    // ======================================================================

    // 4 KiB pages
    parameter int NORMAL_ENTRIES = 32;

    // 4 MiB superpages, tagged on the upper VPN bits only
    parameter int SUPER_ENTRIES  = 4;
    parameter int SUPER_VPN_BITS = 10;

    // Write position must reach every slot of the larger table
    parameter int POS_W = $clog2(NORMAL_ENTRIES);

    // ======================================================================
    // Field types
    // ======================================================================

    typedef logic [ASID_W-1:0] asid_t;
    typedef logic [VPN_W-1:0]  vpn_t;
    typedef logic [PTE_W-1:0]  pte_t;
    typedef logic [POS_W-1:0]  pos_t;

    // Lookup result, one bit per table
    typedef enum logic [1:0] {
        HIT_NONE   = 2'b00,
        HIT_NORMAL = 2'b01,
        HIT_SUPER  = 2'b10
    } hit_kind_t;

endpackage

// File: src/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array #(
    parameter int DEPTH        = mmu_tlb_pkg::NORMAL_ENTRIES,
    parameter int VPN_TAG_BITS = mmu_tlb_pkg::VPN_W
) (
    input  logic                clk,
    input  logic                rstn,

    tlb_update_if.dst           upd,

    // Lookup key
    input  mmu_tlb_pkg::asid_t  i_asid,
    input  mmu_tlb_pkg::vpn_t   i_vpn,

    // Lookup result
    output logic                o_hit,
    output mmu_tlb_pkg::pte_t   o_pte,

    // Per-entry valid bits for replacement
    output logic [DEPTH-1:0]    o_valid
);

    import mmu_tlb_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // ======================================================================
    // Entry storage
    // ======================================================================

    asid_t                   tag_asid [DEPTH];
    logic [VPN_TAG_BITS-1:0] tag_vpn  [DEPTH];
    pte_t                    pte_mem  [DEPTH];

    logic [DEPTH-1:0]        wr_sel;
    logic [DEPTH-1:0]        fl_hit;
    logic [DEPTH-1:0]        rd_hit;

    logic [VPN_TAG_BITS-1:0] wr_vpn_tag;
    logic [VPN_TAG_BITS-1:0] fl_vpn_tag;
    logic [VPN_TAG_BITS-1:0] rd_vpn_tag;

    logic [IDX_W-1:0]        hit_idx;

    // Only the upper VPN bits take part in the tag
    assign wr_vpn_tag = upd.wr_vpn[VPN_W-1 -: VPN_TAG_BITS];
    assign fl_vpn_tag = upd.fl_vpn[VPN_W-1 -: VPN_TAG_BITS];
    assign rd_vpn_tag = i_vpn[VPN_W-1 -: VPN_TAG_BITS];

    // ======================================================================
    // Per-entry compare
    // ======================================================================

    for (genvar i = 0; i < DEPTH; i++) begin : g_entry

        assign wr_sel[i] = upd.wr_en && (upd.wr_pos == pos_t'(i));

        // A zero rs1 or rs2 turns the matching field into a wildcard
        assign fl_hit[i] = upd.fl_en
                        && (upd.fl_all_asid || (tag_asid[i] == upd.fl_asid))
                        && (upd.fl_all_vpn  || (tag_vpn[i]  == fl_vpn_tag));

        assign rd_hit[i] = pte_mem[i][0]
                        && (tag_asid[i] == i_asid)
                        && (tag_vpn[i]  == rd_vpn_tag);

        // Bit 0 of the stored PTE is the valid bit
        assign o_valid[i] = pte_mem[i][0];

    end

    // ======================================================================
    // Write and flush
    // ======================================================================

    // The top level never sends a write and a flush together
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                tag_asid[i] <= '0;
                tag_vpn[i]  <= '0;
                pte_mem[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (wr_sel[i]) begin
                    tag_asid[i] <= upd.wr_asid;
                    tag_vpn[i]  <= wr_vpn_tag;
                    pte_mem[i]  <= upd.wr_pte;
                end else if (fl_hit[i]) begin
                    pte_mem[i][0] <= 1'b0;
                end
            end
        end
    end

    // ======================================================================
    // Lookup
    // ======================================================================

    // Scan downwards so the lowest-indexed hit is the one kept
    always_comb begin
        hit_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (rd_hit[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign o_hit = |rd_hit;
    assign o_pte = o_hit ? pte_mem[hit_idx] : '0;

    // ======================================================================
    // Checks
    // ======================================================================

    // Superpage writes carry a position from the wider 4 KiB range
    a_wr_pos_in_range: assert property (
        @(posedge clk) disable iff (!rstn)
        upd.wr_en |-> (int'(upd.wr_pos) < DEPTH)
    );

    // A written entry takes its valid bit from the new PTE
    a_write_sets_valid: assert property (
        @(posedge clk) disable iff (!rstn)
        upd.wr_en |=> (o_valid[IDX_W'($past(upd.wr_pos))] == $past(upd.wr_pte[0]))
    );

endmodule

// File: src/tlb_update_if.sv
`timescale 1ns/1ps

interface tlb_update_if;

    import mmu_tlb_pkg::*;

    // Write one entry at wr_pos
    logic  wr_en;
    pos_t  wr_pos;
    asid_t wr_asid;
    vpn_t  wr_vpn;
    pte_t  wr_pte;

    // Masked flush of every matching entry
    logic  fl_en;
    asid_t fl_asid;
    vpn_t  fl_vpn;
    logic  fl_all_asid;
    logic  fl_all_vpn;

    // Command side, strobes already resolved for priority
    modport src (
        output wr_en,
        output wr_pos,
        output wr_asid,
        output wr_vpn,
        output wr_pte,
        output fl_en,
        output fl_asid,
        output fl_vpn,
        output fl_all_asid,
        output fl_all_vpn
    );

    // Entry array side
    modport dst (
        input wr_en,
        input wr_pos,
        input wr_asid,
        input wr_vpn,
        input wr_pte,
        input fl_en,
        input fl_asid,
        input fl_vpn,
        input fl_all_asid,
        input fl_all_vpn
    );

endinterface

// File: tests/tlb_ref_model.svh
`ifndef TLB_REF_MODEL_SVH
`define TLB_REF_MODEL_SVH

// Behavioural copy of both tables, indexed like the hardware
asid_t                     m_n_asid [NORMAL_ENTRIES];
vpn_t                      m_n_vpn  [NORMAL_ENTRIES];
pte_t                      m_n_pte  [NORMAL_ENTRIES];
asid_t                     m_s_asid [SUPER_ENTRIES];
logic [SUPER_VPN_BITS-1:0] m_s_vpn  [SUPER_ENTRIES];
pte_t                      m_s_pte  [SUPER_ENTRIES];

task automatic model_clear();
    for (int i = 0; i < NORMAL_ENTRIES; i++) begin
        m_n_asid[i] = '0;
        m_n_vpn[i]  = '0;
        m_n_pte[i]  = '0;
    end
    for (int i = 0; i < SUPER_ENTRIES; i++) begin
        m_s_asid[i] = '0;
        m_s_vpn[i]  = '0;
        m_s_pte[i]  = '0;
    end
endtask

// One clock edge worth of command, 4 KiB write > superpage write > flush
task automatic model_apply(input logic [1:0] wen, input pos_t pos, input asid_t wasid,
                           input vpn_t wvpn, input pte_t wpte, input logic fen,
                           input asid_t fasid, input vpn_t fvpn,
                           input logic [REG_IDX_W-1:0] rs1, input logic [REG_IDX_W-1:0] rs2);
    int  idx;
    logic any_asid;
    logic any_vpn;
    idx      = int'(pos);
    any_vpn  = (rs1 == 0);
    any_asid = (rs2 == 0);
    if (wen[0]) begin
        m_n_asid[idx] = wasid;
        m_n_vpn[idx]  = wvpn;
        m_n_pte[idx]  = wpte;
    end else if (wen[1]) begin
        m_s_asid[idx] = wasid;
        m_s_vpn[idx]  = wvpn[VPN_W-1 -: SUPER_VPN_BITS];
        m_s_pte[idx]  = wpte;
    end else if (fen) begin
        for (int i = 0; i < NORMAL_ENTRIES; i++) begin
            if ((any_asid || m_n_asid[i] == fasid) && (any_vpn || m_n_vpn[i] == fvpn))
                m_n_pte[i][0] = 1'b0;
        end
        for (int i = 0; i < SUPER_ENTRIES; i++) begin
            if ((any_asid || m_s_asid[i] == fasid)
                && (any_vpn || m_s_vpn[i] == fvpn[VPN_W-1 -: SUPER_VPN_BITS]))
                m_s_pte[i][0] = 1'b0;
        end
    end
endtask

// First valid match from index 0 upwards, 4 KiB table first
task automatic model_lookup(input asid_t asid, input vpn_t vpn,
                            output hit_kind_t kind, output pte_t pte);
    kind = HIT_NONE;
    pte  = '0;
    for (int i = 0; i < NORMAL_ENTRIES; i++) begin
        if (kind == HIT_NONE && m_n_pte[i][0] && m_n_asid[i] == asid && m_n_vpn[i] == vpn) begin
            kind = HIT_NORMAL;
            pte  = m_n_pte[i];
        end
    end
    for (int i = 0; i < SUPER_ENTRIES; i++) begin
        if (kind == HIT_NONE && m_s_pte[i][0] && m_s_asid[i] == asid
            && m_s_vpn[i] == vpn[VPN_W-1 -: SUPER_VPN_BITS]) begin
            kind = HIT_SUPER;
            pte  = m_s_pte[i];
        end
    end
endtask

function automatic logic [NORMAL_ENTRIES-1:0] model_normal_valid();
    logic [NORMAL_ENTRIES-1:0] v;
    for (int i = 0; i < NORMAL_ENTRIES; i++)
        v[i] = m_n_pte[i][0];
    return v;
endfunction

function automatic logic [SUPER_ENTRIES-1:0] model_super_valid();
    logic [SUPER_ENTRIES-1:0] v;
    for (int i = 0; i < SUPER_ENTRIES; i++)
        v[i] = m_s_pte[i][0];
    return v;
endfunction

`endif

// File: tests/tb_l1tlb_entry_store.sv
`timescale 1ns/1ps

module tb_l1tlb_entry_store;

    import mmu_tlb_pkg::*;

    localparam int RESET_CYCLES    = 2;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES);

    localparam asid_t A1 = 9'h003;
    localparam asid_t A2 = 9'h07c;
    localparam vpn_t  V1 = 20'h12345;
    localparam vpn_t  V2 = 20'h12346;
    localparam vpn_t  V3 = 20'h00abc;

    logic                  clk;
    logic                  rstn;
    logic [1:0]            i_write_en;
    pos_t                  i_write_pos;
    vpn_t                  i_write_vpn;
    asid_t                 i_write_asid;
    pte_t                  i_write_pte;
    logic                  i_flush_en;
    vpn_t                  i_flush_vpn;
    asid_t                 i_flush_asid;
    logic [REG_IDX_W-1:0]  i_flush_rs1;
    logic [REG_IDX_W-1:0]  i_flush_rs2;
    asid_t                 i_read_asid;
    vpn_t                  i_read_vpn;
    hit_kind_t             o_hit;
    pte_t                  o_hit_pte;
    logic [NORMAL_ENTRIES-1:0] o_normal_valid;
    logic [SUPER_ENTRIES-1:0]  o_super_valid;

    integer seed = 96281;
    int     cycle_count = 0;

    `include "tlb_ref_model.svh"

    l1tlb_entry_store uut (
        .clk            (clk),
        .rstn           (rstn),
        .i_write_en     (i_write_en),
        .i_write_pos    (i_write_pos),
        .i_write_vpn    (i_write_vpn),
        .i_write_asid   (i_write_asid),
        .i_write_pte    (i_write_pte),
        .i_flush_en     (i_flush_en),
        .i_flush_vpn    (i_flush_vpn),
        .i_flush_asid   (i_flush_asid),
        .i_flush_rs1    (i_flush_rs1),
        .i_flush_rs2    (i_flush_rs2),
        .i_read_asid    (i_read_asid),
        .i_read_vpn     (i_read_vpn),
        .o_hit          (o_hit),
        .o_hit_pte      (o_hit_pte),
        .o_normal_valid (o_normal_valid),
        .o_super_valid  (o_super_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // ======================================================================
    // Compare tasks
    // ======================================================================

    task automatic check_hit(input string name, input hit_kind_t exp, input hit_kind_t act);
        if (act !== exp) begin
            $display("mismatch %s: hit kind expected %0d actual %0d", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_pte(input string name, input pte_t exp, input pte_t act);
        if (act !== exp) begin
            $display("mismatch %s: pte expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_valid(input string name,
                               input logic [NORMAL_ENTRIES-1:0] exp_n,
                               input logic [NORMAL_ENTRIES-1:0] act_n,
                               input logic [SUPER_ENTRIES-1:0] exp_s,
                               input logic [SUPER_ENTRIES-1:0] act_s);
        if (act_n !== exp_n || act_s !== exp_s) begin
            $display("mismatch %s: valid expected %h/%h actual %h/%h",
                     name, exp_n, exp_s, act_n, act_s);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================

    // Model takes the command the DUT samples at this edge, then the next one is driven
    task automatic drive_cycle(input string name, input logic [1:0] wen, input pos_t pos,
                               input asid_t wasid, input vpn_t wvpn, input pte_t wpte,
                               input logic fen, input asid_t fasid, input vpn_t fvpn,
                               input logic [REG_IDX_W-1:0] rs1,
                               input logic [REG_IDX_W-1:0] rs2,
                               input asid_t rasid, input vpn_t rvpn);
        hit_kind_t exp_kind;
        pte_t      exp_pte;
        @(posedge clk);
        model_apply(i_write_en, i_write_pos, i_write_asid, i_write_vpn, i_write_pte,
                    i_flush_en, i_flush_asid, i_flush_vpn, i_flush_rs1, i_flush_rs2);
        i_write_en   <= wen;
        i_write_pos  <= pos;
        i_write_asid <= wasid;
        i_write_vpn  <= wvpn;
        i_write_pte  <= wpte;
        i_flush_en   <= fen;
        i_flush_asid <= fasid;
        i_flush_vpn  <= fvpn;
        i_flush_rs1  <= rs1;
        i_flush_rs2  <= rs2;
        i_read_asid  <= rasid;
        i_read_vpn   <= rvpn;
        #1;
        model_lookup(i_read_asid, i_read_vpn, exp_kind, exp_pte);
        check_hit(name, exp_kind, o_hit);
        check_pte(name, exp_pte, o_hit_pte);
        check_valid(name, model_normal_valid(), o_normal_valid,
                    model_super_valid(), o_super_valid);
    endtask

    task automatic write_entry(input string name, input logic [1:0] wen, input pos_t pos,
                               input asid_t asid, input vpn_t vpn, input pte_t pte);
        drive_cycle(name, wen, pos, asid, vpn, pte, 1'b0, '0, '0, 5'd1, 5'd1, asid, vpn);
    endtask

    task automatic flush_entries(input string name, input asid_t asid, input vpn_t vpn,
                                 input logic [REG_IDX_W-1:0] rs1,
                                 input logic [REG_IDX_W-1:0] rs2);
        drive_cycle(name, 2'b00, '0, '0, '0, '0, 1'b1, asid, vpn, rs1, rs2, asid, vpn);
    endtask

    task automatic lookup(input string name, input asid_t asid, input vpn_t vpn);
        drive_cycle(name, 2'b00, '0, '0, '0, '0, 1'b0, '0, '0, 5'd1, 5'd1, asid, vpn);
    endtask

    // Keys come from small pools so hits and flush matches happen often
    task automatic random_cycle();
        logic [31:0] r;
        logic [31:0] p;
        asid_t       asids [4];
        logic [9:0]  hi [4];
        logic [9:0]  lo [4];
        vpn_t        wv;
        vpn_t        fv;
        vpn_t        rv;
        logic [1:0]  wen;
        logic        fen;
        asids = '{9'h003, 9'h07c, 9'h1ff, 9'h000};
        hi    = '{10'h001, 10'h2a5, 10'h3ff, 10'h000};
        lo    = '{10'h000, 10'h001, 10'h155, 10'h3ff};
        r  = $random(seed);
        p  = $random(seed);
        wv = {hi[r[4:3]], lo[r[6:5]]};
        fv = {hi[r[8:7]], lo[r[10:9]]};
        rv = {hi[r[12:11]], lo[r[14:13]]};
        p[0] = (r[16:15] != 2'b00);
        wen = 2'b00;
        fen = 1'b0;
        case (r[2:0])
            3'd0, 3'd1: wen = 2'b01;
            3'd2:       wen = 2'b10;
            3'd3:       wen = 2'b11;
            3'd4:       fen = 1'b1;
            3'd5: begin
                wen = 2'b01;
                fen = 1'b1;
            end
            default: ;
        endcase
        drive_cycle("random", wen, (wen == 2'b10) ? pos_t'(r[18:17]) : r[21:17],
                    asids[r[23:22]], wv, p, fen, asids[r[25:24]], fv,
                    {3'b000, r[27:26]}, {3'b000, r[29:28]}, asids[r[31:30]], rv);
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        i_write_en   = '0;
        i_write_pos  = '0;
        i_write_vpn  = '0;
        i_write_asid = '0;
        i_write_pte  = '0;
        i_flush_en   = 1'b0;
        i_flush_vpn  = '0;
        i_flush_asid = '0;
        i_flush_rs1  = 5'd1;
        i_flush_rs2  = 5'd1;
        i_read_asid  = '0;
        i_read_vpn   = '0;
        model_clear();
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;

        lookup("reset_lookup", A1, V1);
        check_hit("reset_lookup", HIT_NONE, o_hit);
        check_valid("reset_lookup", '0, o_normal_valid, '0, o_super_valid);

        write_entry("normal_write", 2'b01, 5'd4, A1, V1, 32'hcafe_0001);
        lookup("normal_hit", A1, V1);
        check_hit("normal_hit", HIT_NORMAL, o_hit);
        check_pte("normal_hit", 32'hcafe_0001, o_hit_pte);
        write_entry("invalid_write", 2'b01, 5'd6, A1, V2, 32'h1234_5670);
        lookup("invalid_miss", A1, V2);
        check_hit("invalid_miss", HIT_NONE, o_hit);

        // Superpage spans every low VPN bit pattern
        write_entry("super_write", 2'b10, 5'd1, A2, {V3[19:10], 10'h000}, 32'h0bad_0001);
        lookup("super_hit", A2, {V3[19:10], 10'h3a7});
        check_hit("super_hit", HIT_SUPER, o_hit);
        check_pte("super_hit", 32'h0bad_0001, o_hit_pte);
        write_entry("super_overlap", 2'b10, 5'd2, A1, V1, 32'h5555_0003);
        lookup("normal_wins", A1, V1);
        check_hit("normal_wins", HIT_NORMAL, o_hit);
        check_pte("normal_wins", 32'hcafe_0001, o_hit_pte);
        write_entry("dup_high", 2'b01, 5'd9, A2, V3, 32'h0000_9001);
        write_entry("dup_low", 2'b01, 5'd7, A2, V3, 32'h0000_7001);
        lookup("lowest_index", A2, V3);
        check_pte("lowest_index", 32'h0000_7001, o_hit_pte);

        flush_entries("flush_exact", A1, V1, 5'd3, 5'd4);
        lookup("after_exact", A1, V1);
        flush_entries("flush_asid", A2, V2, 5'd0, 5'd4);
        lookup("after_asid", A2, V3);
        write_entry("refill_a", 2'b01, 5'd4, A1, V1, 32'hcafe_0001);
        write_entry("refill_b", 2'b10, 5'd3, A2, V1, 32'h7777_0001);
        flush_entries("flush_vpn", A2, {V1[19:10], 10'h0f0}, 5'd2, 5'd0);
        lookup("after_vpn", A2, V1);
        write_entry("refill_c", 2'b01, 5'd11, A2, V2, 32'h0000_b001);
        flush_entries("flush_all", A1, V1, 5'd0, 5'd0);
        lookup("after_all", A2, V2);
        check_valid("after_all", '0, o_normal_valid, '0, o_super_valid);

        drive_cycle("write_beats_flush", 2'b01, 5'd5, A1, V2, 32'h0000_5001,
                    1'b1, A1, V2, 5'd0, 5'd0, A1, V2);
        lookup("write_kept", A1, V2);
        check_hit("write_kept", HIT_NORMAL, o_hit);
        write_entry("both_writes", 2'b11, 5'd3, A2, V3, 32'h0000_3001);
        lookup("normal_only", A2, V3);
        check_valid("normal_only", model_normal_valid(), o_normal_valid,
                    '0, o_super_valid);

        repeat (RANDOM_CYCLES) random_cycle();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
